/* hw/pcs_pkg.sv */
package pcs_pkg;

	////////////////////
	// Block format

	// One 64b/66b block on the line
	localparam int BLOCK_W = 66;
	localparam int PAYLOAD_W = 64;
	// Raw transceiver word
	localparam int SERDES_W = 32;

	// Gearbox holds at most one block plus one word minus a bit
	localparam int GBX_BUF_W = BLOCK_W + SERDES_W - 1;
	localparam int GBX_FILL_W = $clog2(GBX_BUF_W + 1);

	// Sync header codes, bit 0 is first on the line
	localparam logic [1:0] HDR_DATA = 2'b01;
	localparam logic [1:0] HDR_CTRL = 2'b10;

	////////////////////
	// Lock tracking

	localparam int LOCK_GOOD_COUNT = 64;
	localparam int LOCK_BAD_LIMIT = 16;
	localparam int LOCK_WINDOW = 64;
	// Blocks ignored after each slip
	localparam int SLIP_HOLDOFF = 8;
	localparam int GOOD_CNT_W = $clog2(LOCK_GOOD_COUNT);
	localparam int WIN_CNT_W = $clog2(LOCK_WINDOW);
	localparam int BAD_CNT_W = $clog2(LOCK_BAD_LIMIT);
	localparam int HOLDOFF_W = $clog2(SLIP_HOLDOFF + 1);

	// Scrambler polynomial x^58 + x^39 + 1
	localparam int SCR_LEN = 58;
	localparam int SCR_TAP = 39;

	////////////////////
	// Control block types

	localparam int CTRL_TYPE_N = 15;
	localparam logic [0:CTRL_TYPE_N-1][7:0] CTRL_TYPES = {
		8'h1e, 8'h2d, 8'h33, 8'h4b, 8'h55, 8'h66, 8'h78, 8'h87,
		8'h99, 8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff
	};

	// Type byte sits in the low bits, first on the line
	typedef struct packed {
		logic [55:0] body;
		logic [7:0]  block_type;
	} pcs_ctrl_s;

	// Same 64 bits seen as data bytes or as a control block
	typedef union packed {
		logic [7:0][7:0] data;
		pcs_ctrl_s       ctrl;
	} pcs_payload_u;

	typedef enum logic [1:0] {
		KIND_DATA  = 2'd0,
		KIND_CTRL  = 2'd1,
		KIND_ERROR = 2'd2
	} blk_kind_e;

endpackage

/* hw/rx_gearbox.sv */
module rx_gearbox (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [pcs_pkg::SERDES_W-1:0]  serdes_data,
	input  logic                          bitslip,
	output logic                          block_valid,
	output logic [1:0]                    block_header,
	output logic [pcs_pkg::PAYLOAD_W-1:0] block_payload
);
	import pcs_pkg::*;

	// Line-ordered bit buffer, bit 0 is the oldest bit held
	logic [GBX_BUF_W-1:0]  buf_q;
	// Number of valid bits in buf_q
	logic [GBX_FILL_W-1:0] fill_q;

	// Buffer after this cycle's word and optional slip
	logic [GBX_BUF_W-1:0]  avail;
	logic [GBX_FILL_W-1:0] avail_cnt;
	logic                  blk_ready;

	////////////////////
	// Append and slip

	always_comb begin
		// New word lands right above the buffered bits
		avail = buf_q | (GBX_BUF_W'(serdes_data) << fill_q);
		avail_cnt = fill_q + GBX_FILL_W'(SERDES_W);

		// Slip drops the oldest bit
		// Never empty here, at least one full word is present
		if (bitslip) begin
			avail = avail >> 1;
			avail_cnt = avail_cnt - GBX_FILL_W'(1);
		end

		blk_ready = (avail_cnt >= GBX_FILL_W'(BLOCK_W));
	end

	////////////////////
	// Block extraction

	// Bits above fill_q stay zero so the OR above is safe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			buf_q <= '0;
			fill_q <= '0;
			block_valid <= 1'b0;
		end else begin
			block_valid <= blk_ready;
			if (blk_ready) begin
				// Consume one block from the bottom
				buf_q <= avail >> BLOCK_W;
				fill_q <= avail_cnt - GBX_FILL_W'(BLOCK_W);
			end else begin
				buf_q <= avail;
				fill_q <= avail_cnt;
			end
		end
	end

	// Header first on the line, then payload bit 0 upward
	always_ff @(posedge clk) begin
		if (blk_ready) begin
			block_header <= avail[1:0];
			block_payload <= avail[BLOCK_W-1:2];
		end
	end

	// Fill never exceeds 65 after a cycle
	// 32 in per cycle vs 66 out, so blocks never come back to back

endmodule

/* hw/block_lock.sv */
module block_lock (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               block_valid,
	input  logic [1:0]         block_header,
	output logic               bitslip,
	output logic               hdr_ok,
	output pcs_pkg::blk_kind_e hdr_kind,
	output logic               locked,
	output logic [15:0]        bitslip_count
);
	import pcs_pkg::*;

	logic                  hdr_good;
	logic [GOOD_CNT_W-1:0] good_cnt;
	logic [WIN_CNT_W-1:0]  win_cnt;
	logic [BAD_CNT_W-1:0]  bad_cnt;
	logic [HOLDOFF_W-1:0]  holdoff;

	// Only 01 and 10 are legal sync headers
	assign hdr_good = (block_header == HDR_DATA) || (block_header == HDR_CTRL);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bitslip <= 1'b0;
			hdr_ok <= 1'b0;
			hdr_kind <= KIND_ERROR;
			locked <= 1'b0;
			bitslip_count <= '0;
			good_cnt <= '0;
			win_cnt <= '0;
			bad_cnt <= '0;
			holdoff <= '0;
		end else begin
			// Slip is a single-cycle pulse
			bitslip <= 1'b0;
			if (block_valid) begin
				// Header result, aligned with the descrambler output
				hdr_ok <= hdr_good;
				if (block_header == HDR_DATA)
					hdr_kind <= KIND_DATA;
				else if (block_header == HDR_CTRL)
					hdr_kind <= KIND_CTRL;
				else
					hdr_kind <= KIND_ERROR;

				////////////////////
				// Hunting for alignment
				if (!locked) begin
					if (holdoff != '0) begin
						// Let the slipped alignment settle
						holdoff <= holdoff - HOLDOFF_W'(1);
					end else if (!hdr_good) begin
						bitslip <= 1'b1;
						bitslip_count <= bitslip_count + 16'd1;
						good_cnt <= '0;
						holdoff <= HOLDOFF_W'(SLIP_HOLDOFF);
					end else if (good_cnt == GOOD_CNT_W'(LOCK_GOOD_COUNT - 1)) begin
						// Enough clean headers in a row
						locked <= 1'b1;
						good_cnt <= '0;
						win_cnt <= '0;
						bad_cnt <= '0;
					end else begin
						good_cnt <= good_cnt + GOOD_CNT_W'(1);
					end

				////////////////////
				// Locked, count errors per window
				end else begin
					if (!hdr_good && bad_cnt == BAD_CNT_W'(LOCK_BAD_LIMIT - 1)) begin
						// Too many bad headers, start hunting again
						locked <= 1'b0;
						good_cnt <= '0;
						holdoff <= '0;
					end else if (win_cnt == WIN_CNT_W'(LOCK_WINDOW - 1)) begin
						win_cnt <= '0;
						bad_cnt <= '0;
					end else begin
						win_cnt <= win_cnt + WIN_CNT_W'(1);
						bad_cnt <= bad_cnt + BAD_CNT_W'(!hdr_good);
					end
				end
			end
		end
	end

endmodule

/* hw/rx_descrambler.sv */
module rx_descrambler (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          block_valid,
	input  logic [pcs_pkg::PAYLOAD_W-1:0] block_payload,
	output logic                          descr_valid,
	output logic [pcs_pkg::PAYLOAD_W-1:0] descr_payload
);
	import pcs_pkg::*;

	// Last 58 scrambled bits, bit 57 the most recent
	logic [SCR_LEN-1:0]           state_q;
	// History followed by this block, oldest bit at 0
	logic [SCR_LEN+PAYLOAD_W-1:0] line_bits;
	logic [PAYLOAD_W-1:0]         descr_d;

	assign line_bits = {block_payload, state_q};

	// Payload bit i sits at line_bits[58+i]
	// Tap 39 back is line_bits[19+i], tap 58 back is line_bits[i]
	assign descr_d = block_payload
		^ line_bits[SCR_LEN-SCR_TAP +: PAYLOAD_W]
		^ line_bits[0 +: PAYLOAD_W];

	////////////////////
	// State and strobe

	// Self-synchronising, so it advances on every block
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= '0;
			descr_valid <= 1'b0;
		end else begin
			descr_valid <= block_valid;
			if (block_valid)
				state_q <= block_payload[PAYLOAD_W-1 -: SCR_LEN];
		end
	end

	always_ff @(posedge clk) begin
		if (block_valid)
			descr_payload <= descr_d;
	end

endmodule

/* hw/rx_block_classify.sv */
module rx_block_classify (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  descr_valid,
	input  pcs_pkg::pcs_payload_u descr_payload,
	input  logic                  hdr_ok,
	input  pcs_pkg::blk_kind_e    hdr_kind,
	input  logic                  locked,
	output logic                  rx_valid,
	output pcs_pkg::blk_kind_e    rx_kind,
	output pcs_pkg::pcs_payload_u rx_payload
);
	import pcs_pkg::*;

	logic      type_legal;
	logic      emit;
	blk_kind_e kind_d;

	// Nothing leaves until alignment is trusted
	assign emit = descr_valid && locked;

	////////////////////
	// Type byte lookup

	always_comb begin
		type_legal = 1'b0;
		for (int i = 0; i < CTRL_TYPE_N; i++) begin
			if (descr_payload.ctrl.block_type == CTRL_TYPES[i])
				type_legal = 1'b1;
		end
	end

	// Bad header wins, then header kind, then type check
	always_comb begin
		if (!hdr_ok)
			kind_d = KIND_ERROR;
		else if (hdr_kind == KIND_DATA)
			kind_d = KIND_DATA;
		else if (type_legal)
			kind_d = KIND_CTRL;
		else
			kind_d = KIND_ERROR;
	end

	////////////////////
	// Output register

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rx_valid <= 1'b0;
		else
			rx_valid <= emit;
	end

	// Kind and payload only change with a new block
	always_ff @(posedge clk) begin
		if (emit) begin
			rx_kind <= kind_d;
			rx_payload <= descr_payload;
		end
	end

endmodule

/* hw/pcs_rx_top.sv */
module pcs_rx_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [pcs_pkg::SERDES_W-1:0] serdes_data,
	output logic                         rx_valid,
	output pcs_pkg::blk_kind_e           rx_kind,
	output pcs_pkg::pcs_payload_u        rx_payload,
	output logic                         block_lock,
	output logic [15:0]                  bitslip_count
);
	import pcs_pkg::*;

	// Gearbox to lock tracker and descrambler
	logic                 block_valid;
	logic [1:0]           block_header;
	logic [PAYLOAD_W-1:0] block_payload;

	// Lock tracker results
	logic                 bitslip;
	logic                 hdr_ok;
	blk_kind_e            hdr_kind;

	// Descrambled payload
	logic                 descr_valid;
	logic [PAYLOAD_W-1:0] descr_payload;

	rx_gearbox u_rx_gearbox (
		.clk           (clk),
		.arst_n        (arst_n),
		.serdes_data   (serdes_data),
		.bitslip       (bitslip),
		.block_valid   (block_valid),
		.block_header  (block_header),
		.block_payload (block_payload)
	);

	// Header check path
	block_lock u_block_lock (
		.clk           (clk),
		.arst_n        (arst_n),
		.block_valid   (block_valid),
		.block_header  (block_header),
		.bitslip       (bitslip),
		.hdr_ok        (hdr_ok),
		.hdr_kind      (hdr_kind),
		.locked        (block_lock),
		.bitslip_count (bitslip_count)
	);

	// Payload path, runs alongside the lock tracker
	rx_descrambler u_rx_descrambler (
		.clk           (clk),
		.arst_n        (arst_n),
		.block_valid   (block_valid),
		.block_payload (block_payload),
		.descr_valid   (descr_valid),
		.descr_payload (descr_payload)
	);

	rx_block_classify u_rx_block_classify (
		.clk           (clk),
		.arst_n        (arst_n),
		.descr_valid   (descr_valid),
		.descr_payload (descr_payload),
		.hdr_ok        (hdr_ok),
		.hdr_kind      (hdr_kind),
		.locked        (block_lock),
		.rx_valid      (rx_valid),
		.rx_kind       (rx_kind),
		.rx_payload    (rx_payload)
	);

endmodule

/* verification/pcs_rx_asserts.sv */
module pcs_rx_asserts (
	input logic clk,
	input logic arst_n,
	input logic block_valid,
	input logic bitslip,
	input logic locked,
	input logic rx_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// Gearbox rate

	// A block takes 66 bits and a word brings only 32
	a_block_gap : assert property (@(posedge clk) disable iff (!arst_n)
		block_valid |=> !block_valid)
		else $error("block_valid high on two consecutive cycles");

	////////////////////
	// Lock rules

	// Output only once alignment is trusted
	a_valid_locked : assert property (@(posedge clk) disable iff (!arst_n)
		rx_valid |-> locked)
		else $error("rx_valid while not locked");

	// Slips belong to the hunting state
	a_slip_unlocked : assert property (@(posedge clk) disable iff (!arst_n)
		bitslip |-> !locked)
		else $error("bitslip while locked");

endmodule

bind pcs_rx_top pcs_rx_asserts u_pcs_rx_asserts (
	.clk         (clk),
	.arst_n      (arst_n),
	.block_valid (block_valid),
	.bitslip     (bitslip),
	.locked      (block_lock),
	.rx_valid    (rx_valid)
);

/* verification/pcs_rx_tb.sv */
module pcs_rx_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pcs_pkg::*;

	// Segment kinds
	localparam int SEG_DATA = 0;
	localparam int SEG_CTRL_OK = 1;
	localparam int SEG_CTRL_BAD = 2;
	localparam int SEG_HDR_BAD = 3;
	localparam int NSEG = 19;
	localparam int GARBAGE_BITS = 23;
	localparam logic [63:0] FIXED_PAYLOAD = 64'h55aa_0ff0_c33c_9669;

	typedef struct {
		int         kind;
		int         count;
		bit         fixed;
		logic [7:0] ctrl_type;
	} seg_t;

	// Kind, blocks, fixed payload, control type byte
	// Burst of 32 drops lock wherever the 64-block window wraps
	seg_t segs [NSEG] = '{
		'{SEG_DATA, 600, 0, 8'h00}, '{SEG_CTRL_OK, 4, 0, 8'h1e},
		'{SEG_DATA, 8, 1, 8'h00}, '{SEG_CTRL_OK, 3, 1, 8'h78},
		'{SEG_CTRL_OK, 2, 0, 8'hff}, '{SEG_CTRL_BAD, 3, 0, 8'h00},
		'{SEG_CTRL_BAD, 2, 1, 8'h3c}, '{SEG_DATA, 10, 0, 8'h00},
		'{SEG_HDR_BAD, 1, 0, 8'h00}, '{SEG_DATA, 12, 0, 8'h00},
		'{SEG_HDR_BAD, 1, 1, 8'h00}, '{SEG_DATA, 12, 0, 8'h00},
		'{SEG_HDR_BAD, 1, 0, 8'h00}, '{SEG_DATA, 20, 0, 8'h00},
		'{SEG_HDR_BAD, 32, 0, 8'h00}, '{SEG_DATA, 1200, 0, 8'h00},
		'{SEG_CTRL_OK, 4, 0, 8'h2d}, '{SEG_CTRL_BAD, 2, 0, 8'h5a},
		'{SEG_DATA, 6, 0, 8'h00}
	};

	logic         clk;
	logic         arst_n;
	logic [31:0]  serdes_data;
	logic         rx_valid;
	blk_kind_e    rx_kind;
	pcs_payload_u rx_payload;
	logic         block_lock;
	logic [15:0]  bitslip_count;

	logic [31:0] lfsr;
	// Scrambled history, bit 0 newest
	logic [57:0] scr_hist;
	logic [31:0] ser_word;
	int          ser_cnt;
	blk_kind_e   exp_kind [$];
	logic [63:0] exp_data [$];
	int          val_errs, other_errs, checked, cycles, limit, lock_gains, lock_drops;
	bit          aligned, lock_prev;

	pcs_rx_top u_pcs_rx_top (
		.clk           (clk),
		.arst_n        (arst_n),
		.serdes_data   (serdes_data),
		.rx_valid      (rx_valid),
		.rx_kind       (rx_kind),
		.rx_payload    (rx_payload),
		.block_lock    (block_lock),
		.bitslip_count (bitslip_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Stimulus helpers

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	task automatic rand_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
	endtask

	// Bit 0 of each word goes first on the line
	// Full word goes out on the current edge, then wait for the next one
	task automatic send_bit(input logic b);
		ser_word[ser_cnt] = b;
		ser_cnt++;
		if (ser_cnt == 32) begin
			serdes_data <= ser_word;
			ser_cnt = 0;
			@(posedge clk);
		end
	endtask

	// Scramble with out = in ^ out[-39] ^ out[-58], then header and payload
	task automatic send_block(input logic [1:0] hdr, input logic [63:0] pay, input blk_kind_e k);
		logic [63:0] scr;
		exp_kind.push_back(k);
		exp_data.push_back(pay);
		for (int i = 0; i < 64; i++) begin
			scr[i] = pay[i] ^ scr_hist[38] ^ scr_hist[57];
			scr_hist = {scr_hist[56:0], scr[i]};
		end
		send_bit(hdr[0]);
		send_bit(hdr[1]);
		for (int i = 0; i < 64; i++)
			send_bit(scr[i]);
	endtask

	////////////////////
	// Output checks

	task automatic check_output();
		// After each lock gain, skip blocks lost while hunting
		if (!aligned) begin
			while (exp_data.size() != 0 && exp_data[0] !== rx_payload) begin
				void'(exp_data.pop_front());
				void'(exp_kind.pop_front());
			end
			aligned = 1'b1;
		end
		if (exp_data.size() == 0) begin
			other_errs++;
			$display("Output block arrived with no expected block left");
		end else begin
			checked++;
			if (rx_kind !== exp_kind[0]) begin
				val_errs++;
				$display("CHECK FAILED rx_kind got %h expected %h", rx_kind, exp_kind[0]);
			end
			if (rx_payload !== exp_data[0]) begin
				val_errs++;
				$display("CHECK FAILED rx_payload got %h expected %h", rx_payload, exp_data[0]);
			end
			void'(exp_data.pop_front());
			void'(exp_kind.pop_front());
		end
	endtask

	// Outputs settle after the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (arst_n) begin
			cycles++;
			if (block_lock && !lock_prev) begin
				lock_gains++;
				if (lock_gains == 1 && bitslip_count > 16'd66) begin
					other_errs++;
					$display("First lock took %0d bitslips, more than 66", bitslip_count);
				end
			end
			if (!block_lock && lock_prev) begin
				lock_drops++;
				aligned = 1'b0;
			end
			lock_prev = block_lock;
			if (rx_valid)
				check_output();
			if (cycles > limit) begin
				$display("Timeout after %0d cycles, %0d blocks never came out", cycles, exp_kind.size());
				$display("Simulation failed");
				$finish;
			end
		end
	end

	////////////////////
	// Main sequence

	initial begin
		logic [63:0] pay;
		int          bits;
		arst_n = 1'b0;
		serdes_data = '0;
		lfsr = 32'he1e7d047;
		scr_hist = '0;
		ser_word = '0;
		ser_cnt = 0;
		{val_errs, other_errs, checked, cycles, lock_gains, lock_drops} = '0;
		aligned = 1'b0;
		lock_prev = 1'b0;
		bits = GARBAGE_BITS;
		for (int s = 0; s < NSEG; s++)
			bits += 66 * segs[s].count;
		limit = ((bits + 31) / 32) * 2 + 200;

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		// Misaligned start forces the gearbox to slip
		for (int i = 0; i < GARBAGE_BITS; i++) begin
			rand_bits(1, pay);
			send_bit(pay[0]);
		end
		for (int s = 0; s < NSEG; s++) begin
			for (int n = 0; n < segs[s].count; n++) begin
				if (segs[s].fixed)
					pay = FIXED_PAYLOAD;
				else
					rand_bits(64, pay);
				case (segs[s].kind)
					SEG_DATA:     send_block(2'b01, pay, KIND_DATA);
					SEG_CTRL_OK:  send_block(2'b10, {pay[63:8], segs[s].ctrl_type}, KIND_CTRL);
					SEG_CTRL_BAD: send_block(2'b10, {pay[63:8], segs[s].ctrl_type}, KIND_ERROR);
					default:      send_block(n[0] ? 2'b11 : 2'b00, pay, KIND_ERROR);
				endcase
			end
		end
		// Pad the last word, fewer than 32 bits so no extra block forms
		while (ser_cnt != 0)
			send_bit(1'b0);

		while (exp_kind.size() != 0)
			@(negedge clk);
		if (lock_gains != 2 || lock_drops != 1 || !block_lock) begin
			other_errs++;
			$display("Lock gained %0d times and lost %0d times, expected 2 and 1",
				lock_gains, lock_drops);
		end
		$display("Checked %0d blocks, %0d value errors, %0d other errors",
			checked, val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* files.f */
hw/pcs_pkg.sv
hw/rx_gearbox.sv
hw/block_lock.sv
hw/rx_descrambler.sv
hw/rx_block_classify.sv
hw/pcs_rx_top.sv
verification/pcs_rx_asserts.sv
verification/pcs_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the pass line shows up

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module pcs_rx_tb -f files.f -o pcs_rx_sim &&
obj_dir/pcs_rx_sim | tee /dev/stderr | grep -q "Simulation passed" &&
echo "Run passed" ||
{ echo "Run did not pass"; exit 1; }
